//--- cachePkg.sv
// Shared widths for the instruction-fetch cache
// Requester and memory strobe structs

package cachePkg;

        localparam int AddrWidth = 32; // Byte address
        localparam int DataWidth = 32; // One instruction word
        localparam int CountWidth = 20; // Statistics counters

        // Requester to cache, addr is word aligned
        typedef struct packed {
                logic valid;
                logic [AddrWidth-1:0] addr;
        } fetchReq_t;

        // Cache to requester
        typedef struct packed {
                logic valid;
                logic hit; // Cleared when the word came from memory
                logic [DataWidth-1:0] data;
        } fetchResp_t;

        // Controller to main memory
        typedef struct packed {
                logic valid;
                logic [AddrWidth-1:0] addr;
        } memReq_t;

        // Main memory to controller
        typedef struct packed {
                logic valid;
                logic [DataWidth-1:0] data;
        } memResp_t;

endpackage

//--- cacheWays.sv
`timescale 1ns/1ns
// Two-way set-associative tag and data store
// Combinational hit compare, recency update on touch, victim fill

module cacheWays #(
        parameter int NumSets = 4
) (
        input  logic CLK,
        input  logic RESET,
        input  logic [cachePkg::AddrWidth-1:0] lookupAddr,
        output logic hit,
        output logic [cachePkg::DataWidth-1:0] hitData,
        input  logic touch,
        input  logic fill,
        input  logic [cachePkg::DataWidth-1:0] fillData
);

        localparam int IndexWidth = $clog2(NumSets);
        localparam int TagWidth = cachePkg::AddrWidth - 2 - IndexWidth;

        typedef struct packed {
                logic [TagWidth-1:0] tag;
                logic [cachePkg::DataWidth-1:0] data;
        } wayLine_t;

        wayLine_t wayLines [2][NumSets]; // Tag and word per way and set
        logic [1:0] validBits [NumSets]; // Bit w belongs to way w
        logic [1:0] recentBits [NumSets]; // Set bit marks the recent way

        logic [IndexWidth-1:0] setIdx;
        logic [TagWidth-1:0] lookupTag;
        logic [1:0] wayHit;
        logic victim;

        assign setIdx = lookupAddr[2 +: IndexWidth]; // Just above byte offset
        assign lookupTag = lookupAddr[cachePkg::AddrWidth-1 -: TagWidth];

        always_comb begin
                for (int w = 0; w < 2; w++) begin
                        wayHit[w] = validBits[setIdx][w] &&
                                    (wayLines[w][setIdx].tag == lookupTag);
                end
        end

        assign hit = |wayHit;
        assign hitData = wayHit[1] ? wayLines[1][setIdx].data : wayLines[0][setIdx].data;

        // Way 0 unless it is the recent one
        assign victim = recentBits[setIdx][0];

        always_ff @(posedge CLK) begin
                if (!RESET) begin
                        for (int s = 0; s < NumSets; s++) begin
                                validBits[s] <= 2'b00;
                                recentBits[s] <= 2'b00;
                        end
                end else if (fill) begin
                        validBits[setIdx][victim] <= 1'b1;
                        recentBits[setIdx] <= victim ? 2'b10 : 2'b01; // Filled way recent
                end else if (touch) begin
                        recentBits[setIdx] <= wayHit; // One-hot on a hit
                end
        end

        always_ff @(posedge CLK) begin
                if (fill) begin
                        wayLines[victim][setIdx] <= '{tag: lookupTag, data: fillData};
                end
        end

endmodule

//--- cacheControl.sv
`timescale 1ns/1ns
// Fetch sequencer for the instruction cache
// Lookup, miss fetch from main memory, fill and response

module cacheControl (
        input  logic CLK,
        input  logic RESET,
        input  cachePkg::fetchReq_t fetchReq,
        output cachePkg::fetchResp_t fetchResp,
        output logic [cachePkg::AddrWidth-1:0] lookupAddr,
        input  logic hit,
        input  logic [cachePkg::DataWidth-1:0] hitData,
        output logic touch,
        output logic fill,
        output logic [cachePkg::DataWidth-1:0] fillData,
        output cachePkg::memReq_t memReq,
        input  cachePkg::memResp_t memResp,
        output logic hitEvent,
        output logic missEvent
);

        typedef enum logic [1:0] {
                idle,
                lookup,
                missWait
        } ctrlState_t;

        ctrlState_t state;

        logic [cachePkg::AddrWidth-1:0] reqAddr; // Latched request address
        logic respValid;
        logic respHit;
        logic [cachePkg::DataWidth-1:0] respData;
        logic memReqValid;
        logic memReturn;

        assign memReturn = (state == missWait) && memResp.valid;

        // Control state
        always_ff @(posedge CLK) begin
                if (!RESET) begin
                        state <= idle;
                        respValid <= 1'b0;
                        memReqValid <= 1'b0;
                end else begin
                        respValid <= 1'b0; // Strobes last one cycle
                        memReqValid <= 1'b0;
                        case (state)
                                idle: begin
                                        if (fetchReq.valid) begin
                                                state <= lookup;
                                        end
                                end
                                lookup: begin
                                        if (hit) begin
                                                state <= idle;
                                                respValid <= 1'b1;
                                        end else begin
                                                state <= missWait;
                                                memReqValid <= 1'b1;
                                        end
                                end
                                missWait: begin
                                        if (memResp.valid) begin
                                                state <= idle;
                                                respValid <= 1'b1;
                                        end
                                end
                                default: state <= idle;
                        endcase
                end
        end

        // Address and response payload
        always_ff @(posedge CLK) begin
                if (state == idle && fetchReq.valid) begin
                        reqAddr <= fetchReq.addr;
                end
                if (state == lookup) begin
                        respHit <= hit;
                        respData <= hitData; // Only forwarded on a hit
                end
                if (memReturn) begin
                        respHit <= 1'b0;
                        respData <= memResp.data;
                end
        end

        assign lookupAddr = reqAddr;

        // Way updates land on the same edge as the response
        assign touch = (state == lookup) && hit;
        assign fill = memReturn;
        assign fillData = memResp.data;

        assign hitEvent = (state == lookup) && hit;
        assign missEvent = (state == lookup) && !hit;

        assign memReq.valid = memReqValid;
        assign memReq.addr = reqAddr;

        assign fetchResp.valid = respValid;
        assign fetchResp.hit = respHit;
        assign fetchResp.data = respData;

endmodule

//--- statCounters.sv
`timescale 1ns/1ns
// Hit and miss event counters
// Both hold at all ones instead of wrapping

module statCounters (
        input  logic CLK,
        input  logic RESET,
        input  logic hitEvent,
        input  logic missEvent,
        output logic [cachePkg::CountWidth-1:0] hitCount,
        output logic [cachePkg::CountWidth-1:0] missCount
);

        // Next value of one saturating counter
        function automatic logic [cachePkg::CountWidth-1:0] nextCount(
                input logic [cachePkg::CountWidth-1:0] count,
                input logic event_
        );
                if (event_ && !(&count)) begin
                        return count + 1'b1;
                end
                return count;
        endfunction

        always_ff @(posedge CLK) begin
                if (!RESET) begin
                        hitCount <= '0;
                        missCount <= '0;
                end else begin
                        hitCount <= nextCount(hitCount, hitEvent);
                        missCount <= nextCount(missCount, missEvent);
                end
        end

endmodule

//--- mainMemory.sv
`timescale 1ns/1ns
// Word memory loaded from memInit.hex
// Fixed read latency through a shift pipeline

module mainMemory #(
        parameter int MemLatency = 3,
        parameter int MemWords = 32
) (
        input  logic CLK,
        input  logic RESET,
        input  cachePkg::memReq_t memReq,
        output cachePkg::memResp_t memResp
);

        localparam int IdxWidth = $clog2(MemWords);

        logic [cachePkg::DataWidth-1:0] memArray [MemWords];

        logic [cachePkg::AddrWidth-3:0] wordAddr;
        logic [IdxWidth-1:0] wordIdx;
        logic [MemLatency-1:0] validPipe;
        logic [cachePkg::DataWidth-1:0] dataPipe [MemLatency];

        initial begin
                $readmemh("memInit.hex", memArray);
        end

        assign wordAddr = memReq.addr[cachePkg::AddrWidth-1:2]; // Drop byte offset
        assign wordIdx = IdxWidth'(wordAddr % MemWords); // Wraps over the array

        // Valid strobes, one stage per cycle of latency
        always_ff @(posedge CLK) begin
                if (!RESET) begin
                        validPipe <= '0;
                end else begin
                        validPipe[0] <= memReq.valid;
                        for (int i = 1; i < MemLatency; i++) begin
                                validPipe[i] <= validPipe[i-1];
                        end
                end
        end

        // Read word travels beside its strobe
        always_ff @(posedge CLK) begin
                dataPipe[0] <= memArray[wordIdx];
                for (int i = 1; i < MemLatency; i++) begin
                        dataPipe[i] <= dataPipe[i-1];
                end
        end

        assign memResp.valid = validPipe[MemLatency-1];
        assign memResp.data = dataPipe[MemLatency-1];

endmodule

//--- icacheTop.sv
`timescale 1ns/1ns
// Instruction-fetch cache subsystem top level
// Controller, two-way store, statistics and main memory

module icacheTop #(
        parameter int NumSets = 4,
        parameter int MemLatency = 3,
        parameter int MemWords = 32
) (
        input  logic CLK,
        input  logic RESET,
        input  cachePkg::fetchReq_t fetchReq,
        output cachePkg::fetchResp_t fetchResp,
        output logic [cachePkg::CountWidth-1:0] hitCount,
        output logic [cachePkg::CountWidth-1:0] missCount
);

        logic [cachePkg::AddrWidth-1:0] lookupAddr;
        logic hit;
        logic [cachePkg::DataWidth-1:0] hitData;
        logic touch;
        logic fill;
        logic [cachePkg::DataWidth-1:0] fillData;
        logic hitEvent;
        logic missEvent;
        cachePkg::memReq_t memReq;
        cachePkg::memResp_t memResp;

        cacheControl control (
                .CLK        (CLK),
                .RESET      (RESET),
                .fetchReq   (fetchReq),
                .fetchResp  (fetchResp),
                .lookupAddr (lookupAddr),
                .hit        (hit),
                .hitData    (hitData),
                .touch      (touch),
                .fill       (fill),
                .fillData   (fillData),
                .memReq     (memReq),
                .memResp    (memResp),
                .hitEvent   (hitEvent),
                .missEvent  (missEvent)
        );

        cacheWays #(.NumSets(NumSets)) ways (
                .CLK        (CLK),
                .RESET      (RESET),
                .lookupAddr (lookupAddr),
                .hit        (hit),
                .hitData    (hitData),
                .touch      (touch),
                .fill       (fill),
                .fillData   (fillData)
        );

        statCounters stats (
                .CLK        (CLK),
                .RESET      (RESET),
                .hitEvent   (hitEvent),
                .missEvent  (missEvent),
                .hitCount   (hitCount),
                .missCount  (missCount)
        );

        mainMemory #(.MemLatency(MemLatency), .MemWords(MemWords)) memory (
                .CLK        (CLK),
                .RESET      (RESET),
                .memReq     (memReq),
                .memResp    (memResp)
        );

endmodule

//--- tb_icache.sv
`timescale 1ns/1ns
// Directed testbench for the instruction-fetch cache subsystem
// Clock, reset, reference model of the ways, fetch tasks and watchdog

module tb_icache;

        localparam int NumSets = 4;
        localparam int MemLatency = 3;
        localparam int MemWords = 32;
        localparam int IndexBits = $clog2(NumSets);
        localparam int ResetCycles = 16;
        localparam int RandSeed = 46;
        localparam int RandomFetches = 200;
        localparam int NumFetches = 12 + RandomFetches + 2; // Directed plus random plus reset test
        localparam int WatchdogCycles = NumFetches * (MemLatency + 5) + 100;

        logic CLK;
        logic RESET;
        cachePkg::fetchReq_t fetchReq;
        cachePkg::fetchResp_t fetchResp;
        logic [cachePkg::CountWidth-1:0] hitCount;
        logic [cachePkg::CountWidth-1:0] missCount;

        logic [31:0] refMem [MemWords]; // Expected memory contents
        logic [31:0] refTag [2][NumSets];
        logic refValid [2][NumSets];
        logic [1:0] refRecent [NumSets]; // One-hot recent way, zero after reset
        int refHits;
        int refMisses;

        int mismatchCount = 0;
        int missingCount = 0;

        icacheTop UUT (
                .CLK       (CLK),
                .RESET     (RESET),
                .fetchReq  (fetchReq),
                .fetchResp (fetchResp),
                .hitCount  (hitCount),
                .missCount (missCount)
        );

        initial begin
                CLK = 1'b0;
                forever #50 CLK = ~CLK;
        end

        task automatic compareValue(input string testName, input string what,
                                    input logic [31:0] expected, input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("MISMATCH %s %s: expected %08h, actual %08h",
                                 testName, what, expected, actual);
                        mismatchCount++;
                end
        endtask

        function automatic logic [31:0] memWord(input logic [31:0] addr);
                return refMem[int'((addr >> 2) % MemWords)]; // Word address wraps
        endfunction

        task automatic clearModel();
                for (int s = 0; s < NumSets; s++) begin
                        refValid[0][s] = 1'b0;
                        refValid[1][s] = 1'b0;
                        refRecent[s] = 2'b00;
                end
                refHits = 0;
                refMisses = 0;
        endtask

        // Predicts one access and updates the model ways
        task automatic predictAccess(input logic [31:0] addr, output logic expHit,
                                     output logic [31:0] expData);
                int s;
                int hitWay;
                int victim;
                logic [31:0] tag;
                s = int'((addr >> 2) % NumSets);
                tag = addr >> (2 + IndexBits);
                expData = memWord(addr);
                expHit = 1'b0;
                hitWay = 0;
                for (int w = 0; w < 2; w++) begin
                        if (refValid[w][s] && refTag[w][s] == tag) begin
                                expHit = 1'b1;
                                hitWay = w;
                        end
                end
                if (expHit) begin
                        refRecent[s] = (hitWay == 1) ? 2'b10 : 2'b01;
                        refHits++;
                end else begin
                        victim = refRecent[s][0] ? 1 : 0; // Way with its recency bit clear
                        refValid[victim][s] = 1'b1;
                        refTag[victim][s] = tag;
                        refRecent[s] = (victim == 1) ? 2'b10 : 2'b01;
                        refMisses++;
                end
        endtask

        task automatic applyReset();
                RESET = 1'b0;
                repeat (ResetCycles) @(negedge CLK);
                RESET = 1'b1;
                clearModel();
        endtask

        // Strobes one request, waits for the response and checks it against the model
        task automatic fetchWord(input string testName, input logic [31:0] addr,
                                 output logic gotHit, output logic [31:0] gotData);
                logic expHit;
                logic [31:0] expData;
                int waitCycles;
                predictAccess(addr, expHit, expData);
                @(negedge CLK);
                fetchReq.valid = 1'b1;
                fetchReq.addr = addr;
                @(negedge CLK);
                fetchReq.valid = 1'b0;
                waitCycles = 0;
                while (!fetchResp.valid && waitCycles < MemLatency + 5) begin
                        @(negedge CLK);
                        waitCycles++;
                end
                if (!fetchResp.valid) begin
                        $display("%s: no response to the fetch of address %08h within %0d cycles",
                                 testName, addr, MemLatency + 5);
                        missingCount++;
                        gotHit = 1'bx;
                        gotData = 'x;
                end else begin
                        gotHit = fetchResp.hit;
                        gotData = fetchResp.data;
                        compareValue(testName, "hit", 32'(expHit), 32'(gotHit));
                        compareValue(testName, "data", expData, gotData);
                        compareValue(testName, "hitCount", refHits, 32'(hitCount));
                        compareValue(testName, "missCount", refMisses, 32'(missCount));
                end
        endtask

        task automatic fetchExpect(input string testName, input logic [31:0] addr,
                                   input logic expectHit);
                logic gotHit;
                logic [31:0] gotData;
                fetchWord(testName, addr, gotHit, gotData);
                compareValue(testName, "expected hit flag", 32'(expectHit), 32'(gotHit));
        endtask

        task automatic testColdMiss();
                logic gotHit;
                logic [31:0] gotData;
                fetchWord("coldMiss", 32'h0000_1234, gotHit, gotData); // Word 0x48D, wraps to 13
                compareValue("coldMiss", "hit", 32'd0, 32'(gotHit));
                compareValue("coldMiss", "data", memWord(32'h0000_1234), gotData);
                compareValue("coldMiss", "missCount", 32'd1, 32'(missCount));
        endtask

        task automatic testHitAfterFill();
                logic gotHit;
                logic [31:0] gotData;
                fetchWord("hitAfterFill", 32'h0000_1234, gotHit, gotData);
                compareValue("hitAfterFill", "hit", 32'd1, 32'(gotHit));
                compareValue("hitAfterFill", "data", memWord(32'h0000_1234), gotData);
                compareValue("hitAfterFill", "hitCount", 32'd1, 32'(hitCount));
        endtask

        task automatic testTwoWays();
                fetchExpect("twoWays", 32'h0000_0108, 1'b0); // Set 2, tag 0x10
                fetchExpect("twoWays", 32'h0000_0238, 1'b0); // Set 2, tag 0x23
                fetchExpect("twoWays", 32'h0000_0108, 1'b1);
                fetchExpect("twoWays", 32'h0000_0238, 1'b1);
        endtask

        task automatic testLruEviction();
                fetchExpect("lruEviction", 32'h0000_030C, 1'b0); // A in set 3
                fetchExpect("lruEviction", 32'h0000_041C, 1'b0); // B in set 3
                fetchExpect("lruEviction", 32'h0000_030C, 1'b1); // B now least recent
                fetchExpect("lruEviction", 32'h0000_052C, 1'b0); // C replaces B
                fetchExpect("lruEviction", 32'h0000_030C, 1'b1);
                fetchExpect("lruEviction", 32'h0000_041C, 1'b0);
        endtask

        task automatic testRandomStream();
                logic gotHit;
                logic [31:0] gotData;
                logic [4:0] wordIdx;
                for (int i = 0; i < RandomFetches; i++) begin
                        wordIdx = 5'($urandom % 32); // 8 tags over all 4 sets
                        fetchWord("randomStream", {25'd0, wordIdx, 2'b00}, gotHit, gotData);
                end
                compareValue("randomStream", "final hitCount", refHits, 32'(hitCount));
                compareValue("randomStream", "final missCount", refMisses, 32'(missCount));
        endtask

        task automatic testResetClears();
                logic gotHit;
                logic [31:0] gotData;
                fetchWord("resetClears", 32'h0000_030C, gotHit, gotData); // A cached again
                applyReset();
                compareValue("resetClears", "hitCount", 32'd0, 32'(hitCount));
                compareValue("resetClears", "missCount", 32'd0, 32'(missCount));
                fetchExpect("resetClears", 32'h0000_030C, 1'b0); // Was cached before reset
        endtask

        initial begin
                repeat (WatchdogCycles) @(posedge CLK);
                $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
                $display("Verification failed");
                $finish;
        end

        initial begin
                RESET = 1'b0;
                fetchReq = '0;
                void'($urandom(RandSeed));
                $readmemh("memInit.hex", refMem);
                applyReset();
                testColdMiss();
                testHitAfterFill();
                testTwoWays();
                testLruEviction();
                testRandomStream();
                testResetClears();
                @(negedge CLK);
                $display("Errors: %0d mismatches, %0d missing responses",
                         mismatchCount, missingCount);
                if (mismatchCount == 0 && missingCount == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

//--- memInit.hex
// One 32-bit data word per line, word addresses 0 to 31 in order
A000C300
A001C305
A002C30A
A003C30F
A004C314
A005C319
A006C31E
A007C323
A008C328
A009C32D
A00AC332
A00BC337
A00CC33C
A00DC341
A00EC346
A00FC34B
A010C350
A011C355
A012C35A
A013C35F
A014C364
A015C369
A016C36E
A017C373
A018C378
A019C37D
A01AC382
A01BC387
A01CC38C
A01DC391
A01EC396
A01FC39B

//--- src.f
cachePkg.sv
cacheWays.sv
cacheControl.sv
statCounters.sv
mainMemory.sv
icacheTop.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
# Compile and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_icache -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
        exit 0
fi
exit 1
